//--- evr_rx_pkg.sv
package evr_rx_pkg;

    ////////////////////
    // received word

    localparam int RX_WORD_W = 16;          // decoder output word
    localparam int RX_BYTES  = 2;           // two 8b/10b characters per word

    localparam logic [7:0] K28_5 = 8'hBC;   // comma, only ever in byte 0

    ////////////////////
    // gpio control / status word

    localparam int GPIO_W = 32;             // gpio out and status both 32 bits

    // control field, gpio[30:25]
    //   ctrl[5]  slide request       gpio 30
    //   ctrl[4]  tx reset            gpio 29
    //   ctrl[3]  rx pma reset        gpio 28
    //   ctrl[2]  rx reset            gpio 27
    //   ctrl[1]  pll reset           gpio 26
    //   ctrl[0]  soft reset          gpio 25
    localparam int CTRL_W    = 6;
    localparam int CTRL_LSB  = 25;
    localparam int MGT_RST_W = 5;           // ctrl bits below the slide request

    // status word
    //   bit 31     aligned, synced to sys clock
    //   bits 30:25 control read-back
    //   rest       zero
    localparam int STAT_ALIGNED_BIT = 31;

    ////////////////////
    // word seen two ways
    // whole word for the char output, bytes for comma detect

    typedef union packed {
        logic [RX_WORD_W-1:0]     word;    // raw
        logic [RX_BYTES-1:0][7:0] bytes;   // bytes[0] = low byte
    } rx_word_u;

endpackage

//--- evr_comma_align.sv
`timescale 1ns/1ps

module evr_comma_align import evr_rx_pkg::*; #(
    parameter int COMMAS_NEEDED = 60
) (
    input  logic                 evrClk,
    input  logic                 rst_n_i,
    input  rx_word_u             rx_data_i,
    input  logic [RX_BYTES-1:0]  rx_is_k_i,
    input  logic [RX_BYTES-1:0]  rx_not_in_table_i,
    input  logic [RX_BYTES-1:0]  rx_disp_err_i,
    output logic [RX_WORD_W-1:0] evr_chars_o,
    output logic [RX_BYTES-1:0]  evr_char_is_k_o,
    output logic                 rx_aligned_o
);

    ////////////////////
    // comma counter
    // loads with N-1, counts down, goes aligned on wrap past zero
    // top bit is the aligned flag, so one extra bit over the count

    localparam int CNT_W = $clog2(COMMAS_NEEDED) + 1;
    localparam logic [CNT_W-1:0] CNT_RELOAD = CNT_W'(COMMAS_NEEDED - 1);

    logic [CNT_W-1:0] comma_cnt;
    logic             rx_err;       // any decode problem in this word
    logic             rx_comma;     // K28.5 in byte 0

    // K only legal on byte 0
    assign rx_err   = (|rx_not_in_table_i) || (|rx_disp_err_i) || rx_is_k_i[1];
    assign rx_comma = rx_is_k_i[0] && (rx_data_i.bytes[0] == K28_5);

    assign rx_aligned_o = comma_cnt[CNT_W-1];

    always_ff @(posedge evrClk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            comma_cnt <= CNT_RELOAD;
        end else if (rx_err) begin
            comma_cnt <= CNT_RELOAD;                // start over
        end else if (!rx_aligned_o && rx_comma) begin
            comma_cnt <= comma_cnt - 1'b1;
        end
        // once aligned, commas are ignored
    end

    ////////////////////
    // char output
    // one cycle behind the input, zeroed when unaligned or bad word

    always_ff @(posedge evrClk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            evr_chars_o     <= '0;
            evr_char_is_k_o <= '0;
        end else if (rx_aligned_o && !rx_err) begin
            evr_chars_o     <= rx_data_i.word;    // pass through untouched
            evr_char_is_k_o <= rx_is_k_i;
        end else begin
            evr_chars_o     <= '0;
            evr_char_is_k_o <= '0;
        end
    end

    ////////////////////
    // checks

    // nothing leaks out in the cycle after an unaligned one
    a_gated_when_unaligned : assert property (
        @(posedge evrClk) disable iff (!rst_n_i)
        !rx_aligned_o |=> (evr_chars_o == '0) && (evr_char_is_k_o == '0)
    ) else $error("char output nonzero after unaligned cycle");

endmodule

//--- evr_slide_sync.sv
`timescale 1ns/1ps

module evr_slide_sync (
    input  logic evrClk,
    input  logic rst_n_i,
    input  logic slide_req_i,   // level from sys clock domain
    output logic bit_slide_o    // one evrClk wide
);

    ////////////////////
    // sync + edge detect

    logic req_meta;     // first stage, may go metastable
    logic req_sync;
    logic req_dly;      // previous req_sync for edge detect

    always_ff @(posedge evrClk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            req_meta    <= 1'b0;
            req_sync    <= 1'b0;
            req_dly     <= 1'b0;
            bit_slide_o <= 1'b0;
        end else begin
            req_meta    <= slide_req_i;
            req_sync    <= req_meta;
            req_dly     <= req_sync;
            bit_slide_o <= req_sync && !req_dly;    // rising edge only
        end
    end

    ////////////////////
    // checks

    // transceiver slides one bit per pulse, a double pulse slides two
    a_single_cycle_slide : assert property (
        @(posedge evrClk) disable iff (!rst_n_i)
        bit_slide_o |=> !bit_slide_o
    ) else $error("bit_slide_o held for two cycles");

endmodule

//--- evr_mgt_csr.sv
`timescale 1ns/1ps

module evr_mgt_csr import evr_rx_pkg::*; (
    input  logic                 sys_clk_i,
    input  logic                 rst_n_i,
    input  logic                 csr_strobe_i,
    input  logic [GPIO_W-1:0]    gpio_i,
    input  logic                 rx_aligned_i,    // evrClk domain level
    output logic                 slide_req_o,
    output logic [MGT_RST_W-1:0] mgt_reset_o,
    output logic [GPIO_W-1:0]    csr_status_o
);

    ////////////////////
    // control register

    logic [CTRL_W-1:0] ctrl_q;

    always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctrl_q <= '0;
        end else if (csr_strobe_i) begin
            ctrl_q <= gpio_i[CTRL_LSB +: CTRL_W];   // gpio[30:25]
        end
    end

    assign slide_req_o = ctrl_q[CTRL_W-1];           // top bit
    assign mgt_reset_o = ctrl_q[MGT_RST_W-1:0];      // tx, rx pma, rx, pll, soft

    ////////////////////
    // aligned flag into sys clock

    logic aligned_meta;
    logic aligned_sync;

    always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            aligned_meta <= 1'b0;
            aligned_sync <= 1'b0;
        end else begin
            aligned_meta <= rx_aligned_i;
            aligned_sync <= aligned_meta;
        end
    end

    // status word, unused bits read zero
    always_comb begin
        csr_status_o                        = '0;
        csr_status_o[STAT_ALIGNED_BIT]      = aligned_sync;
        csr_status_o[CTRL_LSB +: CTRL_W]    = ctrl_q;     // read-back
    end

    ////////////////////
    // checks

    // resets to the transceiver move only on a register write
    a_reset_on_strobe : assert property (
        @(posedge sys_clk_i) disable iff (!rst_n_i)
        (mgt_reset_o != $past(mgt_reset_o)) |-> $past(csr_strobe_i)
    ) else $error("mgt_reset_o changed without a strobe");

endmodule

//--- evr_rx_framer.sv
`timescale 1ns/1ps

module evr_rx_framer import evr_rx_pkg::*; #(
    parameter int COMMAS_NEEDED = 60
) (
    // evrClk side, from the 8b/10b decoder
    input  logic                 evrClk,
    input  logic                 rst_n_i,
    input  rx_word_u             rx_data_i,
    input  logic [RX_BYTES-1:0]  rx_is_k_i,
    input  logic [RX_BYTES-1:0]  rx_not_in_table_i,
    input  logic [RX_BYTES-1:0]  rx_disp_err_i,
    output logic [RX_WORD_W-1:0] evr_chars_o,
    output logic [RX_BYTES-1:0]  evr_char_is_k_o,
    output logic                 evr_rx_synchronized_o,
    output logic                 bit_slide_o,

    // system side
    input  logic                 sys_clk_i,
    input  logic [GPIO_W-1:0]    gpio_i,
    input  logic                 csr_strobe_i,
    output logic [MGT_RST_W-1:0] mgt_reset_o,
    output logic [GPIO_W-1:0]    csr_status_o
);

    logic rx_aligned;   // evrClk domain
    logic slide_req;    // sys clock domain

    ////////////////////
    // word alignment

    evr_comma_align #(
        .COMMAS_NEEDED(COMMAS_NEEDED)
    ) evr_comma_align_inst (
        .evrClk            (evrClk),
        .rst_n_i           (rst_n_i),
        .rx_data_i         (rx_data_i),
        .rx_is_k_i         (rx_is_k_i),
        .rx_not_in_table_i (rx_not_in_table_i),
        .rx_disp_err_i     (rx_disp_err_i),
        .evr_chars_o       (evr_chars_o),
        .evr_char_is_k_o   (evr_char_is_k_o),
        .rx_aligned_o      (rx_aligned)
    );

    assign evr_rx_synchronized_o = rx_aligned;

    ////////////////////
    // slide request crossing

    evr_slide_sync evr_slide_sync_inst (
        .evrClk      (evrClk),
        .rst_n_i     (rst_n_i),
        .slide_req_i (slide_req),
        .bit_slide_o (bit_slide_o)
    );

    ////////////////////
    // control / status

    evr_mgt_csr evr_mgt_csr_inst (
        .sys_clk_i    (sys_clk_i),
        .rst_n_i      (rst_n_i),
        .csr_strobe_i (csr_strobe_i),
        .gpio_i       (gpio_i),
        .rx_aligned_i (rx_aligned),     // synced inside
        .slide_req_o  (slide_req),
        .mgt_reset_o  (mgt_reset_o),
        .csr_status_o (csr_status_o)
    );

endmodule

//--- evr_rx_checker.sv
`timescale 1ns/1ps

module evr_rx_checker import evr_rx_pkg::*; (
    input  logic                 evrClk,
    input  logic                 sys_clk_i,
    // dut outputs
    input  logic [RX_WORD_W-1:0] evr_chars_i,
    input  logic [RX_BYTES-1:0]  evr_char_is_k_i,
    input  logic                 evr_rx_synchronized_i,
    input  logic                 bit_slide_i,
    input  logic [MGT_RST_W-1:0] mgt_reset_i,
    input  logic [GPIO_W-1:0]    csr_status_i,
    // expectations, driven with the stimulus
    input  logic                 exp_rx_valid_i,
    input  logic [RX_WORD_W-1:0] exp_chars_i,
    input  logic [RX_BYTES-1:0]  exp_is_k_i,
    input  logic                 exp_sync_i,
    input  logic                 exp_sys_valid_i,
    input  logic [1:0]           exp_sys_kind_i,    // 0 mgt reset, 1 status, 2 slide count
    input  logic [GPIO_W-1:0]    exp_sys_val_i,
    input  int                   test_num_i,
    input  logic                 test_end_i,
    output int                   tests_passed_o,
    output int                   tests_failed_o
);

    // word sent last cycle, due on the outputs now
    logic                 pend_valid = 1'b0;
    logic [RX_WORD_W-1:0] pend_chars;
    logic [RX_BYTES-1:0]  pend_k;
    logic                 pend_sync;

    int   rx_errs   = 0;
    int   sys_errs  = 0;
    int   errs_seen = 0;        // total at the end of the previous test
    int   slide_cnt = 0;
    logic slide_q   = 1'b0;

    initial tests_passed_o = 0;
    initial tests_failed_o = 0;

    function automatic int compare_value(string name, logic [31:0] exp_v, logic [31:0] got_v);
        if (exp_v === got_v) return 0;
        $display("ERROR t=%0t %s expected %0h actual %0h", $time, name, exp_v, got_v);
        return 1;
    endfunction

    ////////////////////
    // evrClk side

    always @(posedge evrClk) begin
        int n;
        int test_errs;
        n = 0;
        if (pend_valid) begin
            n += compare_value("evr_chars_o", 32'(pend_chars), 32'(evr_chars_i));
            n += compare_value("evr_char_is_k_o", 32'(pend_k), 32'(evr_char_is_k_i));
            n += compare_value("evr_rx_synchronized_o", 32'(pend_sync),
                               32'(evr_rx_synchronized_i));
        end
        pend_valid = exp_rx_valid_i;
        pend_chars = exp_chars_i;
        pend_k     = exp_is_k_i;
        pend_sync  = exp_sync_i;

        if (bit_slide_i && !slide_q) slide_cnt = slide_cnt + 1;   // rising edge
        if (bit_slide_i && slide_q) begin
            $display("bit_slide_o stayed high for more than one cycle at t=%0t", $time);
            n++;
        end
        slide_q = bit_slide_i;
        rx_errs = rx_errs + n;

        if (test_end_i) begin
            test_errs = rx_errs + sys_errs - errs_seen;
            errs_seen = rx_errs + sys_errs;
            if (test_errs == 0) begin
                tests_passed_o = tests_passed_o + 1;
                $display("test %0d ok", test_num_i);
            end else begin
                tests_failed_o = tests_failed_o + 1;
                $display("test %0d FAIL with %0d errors", test_num_i, test_errs);
            end
        end
    end

    ////////////////////
    // sys clock side

    always @(posedge sys_clk_i) begin
        if (exp_sys_valid_i) begin
            case (exp_sys_kind_i)
                2'd0: sys_errs += compare_value("mgt_reset_o", exp_sys_val_i, 32'(mgt_reset_i));
                2'd1: sys_errs += compare_value("csr_status_o", exp_sys_val_i, csr_status_i);
                default: sys_errs += compare_value("bit_slide_o pulses", exp_sys_val_i,
                                                   32'(slide_cnt));
            endcase
        end
    end

endmodule

//--- tb_evr_rx_framer.sv
`timescale 1ns/1ps

module tb_evr_rx_framer import evr_rx_pkg::*; ();

    localparam int SYS_PERIOD = 10;
    localparam int MAX_LINES  = 64;
    localparam int SLIDE_WAIT = 16;     // evrClk edges allowed for the slide pulse

    logic                 evrClk  = 1'b0;
    logic                 sys_clk = 1'b0;
    logic                 rst_n, csr_strobe, exp_rx_valid, exp_sync, exp_sys_valid, test_end;
    rx_word_u             rx_data;
    logic [RX_BYTES-1:0]  rx_is_k, rx_nit, rx_disp, exp_k, char_is_k;
    logic [GPIO_W-1:0]    gpio, exp_sys_val, status;
    logic [RX_WORD_W-1:0] exp_chars, chars;
    logic [1:0]           exp_sys_kind;
    logic [MGT_RST_W-1:0] mgt_reset;
    logic                 synced, bit_slide;
    int                   test_num, passed, failed;
    int                   tb_errs     = 0;
    int                   steps_total = 0;
    bit                   slide_level = 1'b0;      // last slide request written

    // trace table with fields data is_k nit disp exp0 exp1 exp2
    int                   t_test [MAX_LINES];
    int                   t_op   [MAX_LINES];
    int                   t_rep  [MAX_LINES];
    logic [31:0]          t_fld  [MAX_LINES][7];

    always #2 evrClk = ~evrClk;                     // 4 ns
    always #(SYS_PERIOD / 2) sys_clk = ~sys_clk;

    evr_rx_framer #(.COMMAS_NEEDED(8)) evr_rx_framer_inst (
        .evrClk(evrClk), .rst_n_i(rst_n), .rx_data_i(rx_data), .rx_is_k_i(rx_is_k),
        .rx_not_in_table_i(rx_nit), .rx_disp_err_i(rx_disp), .evr_chars_o(chars),
        .evr_char_is_k_o(char_is_k), .evr_rx_synchronized_o(synced), .bit_slide_o(bit_slide),
        .sys_clk_i(sys_clk), .gpio_i(gpio), .csr_strobe_i(csr_strobe),
        .mgt_reset_o(mgt_reset), .csr_status_o(status)
    );

    evr_rx_checker evr_rx_checker_inst (
        .evrClk(evrClk), .sys_clk_i(sys_clk), .evr_chars_i(chars), .evr_char_is_k_i(char_is_k),
        .evr_rx_synchronized_i(synced), .bit_slide_i(bit_slide), .mgt_reset_i(mgt_reset),
        .csr_status_i(status), .exp_rx_valid_i(exp_rx_valid), .exp_chars_i(exp_chars),
        .exp_is_k_i(exp_k), .exp_sync_i(exp_sync), .exp_sys_valid_i(exp_sys_valid),
        .exp_sys_kind_i(exp_sys_kind), .exp_sys_val_i(exp_sys_val), .test_num_i(test_num),
        .test_end_i(test_end), .tests_passed_o(passed), .tests_failed_o(failed)
    );

    ////////////////////
    // trace file

    task automatic load_trace(output int lines);
        int    fd;
        int    code;
        string line;
        lines = 0;
        fd = $fopen("evr_rx_trace.txt", "r");
        if (fd == 0) return;
        while (!$feof(fd) && lines < MAX_LINES) begin
            code = $fgets(line, fd);
            if (code == 0 || line.len() < 2 || line.getc(0) == "#") continue;   // header
            code = $sscanf(line, "%d %d %d %h %h %h %h %h %h %h",
                           t_test[lines], t_op[lines], t_rep[lines],
                           t_fld[lines][0], t_fld[lines][1], t_fld[lines][2],
                           t_fld[lines][3], t_fld[lines][4], t_fld[lines][5],
                           t_fld[lines][6]);
            if (code == 10) lines++;
        end
        $fclose(fd);
    endtask

    ////////////////////
    // stimulus

    task automatic post_sys_check(input logic [1:0] kind, input logic [31:0] val);
        @(posedge sys_clk);
        exp_sys_valid <= 1'b1;
        exp_sys_kind  <= kind;
        exp_sys_val   <= val;
        @(posedge sys_clk);
        exp_sys_valid <= 1'b0;                      // checker compares on this edge
    endtask

    task automatic wait_slide_pulse();
        int waited;
        waited = 0;
        while (!bit_slide && waited < SLIDE_WAIT) begin
            @(posedge evrClk);
            waited++;
        end
        if (!bit_slide) begin
            $display("no bit_slide_o pulse within %0d evrClk cycles of a slide request",
                     SLIDE_WAIT);
            tb_errs++;
        end
    endtask

    task automatic run_step(input int i);
        logic [RX_WORD_W-1:0] w;
        case (t_op[i])
            0, 1: repeat (t_rep[i]) begin               // explicit or random idle word
                @(posedge evrClk);
                w = (t_op[i] == 1) ? 16'($urandom()) : t_fld[i][0][15:0];
                rx_data.word <= w;
                rx_is_k      <= (t_op[i] == 1) ? 2'b00 : t_fld[i][1][1:0];
                rx_nit       <= t_fld[i][2][1:0];
                rx_disp      <= t_fld[i][3][1:0];
                exp_rx_valid <= 1'b1;
                exp_chars    <= (t_op[i] == 0) ? t_fld[i][4][15:0] :
                                (t_fld[i][4][0] ? w : 16'h0000);   // idle passes when aligned
                exp_k        <= t_fld[i][5][1:0];
                exp_sync     <= t_fld[i][6][0];
            end
            2: begin                                    // csr write
                @(posedge sys_clk);
                gpio       <= t_fld[i][0];
                csr_strobe <= 1'b1;
                @(posedge sys_clk);
                csr_strobe <= 1'b0;
                if (t_fld[i][0][30] && !slide_level) wait_slide_pulse();
                slide_level = t_fld[i][0][30];
                post_sys_check(2'd0, t_fld[i][4]);
            end
            3: begin
                repeat (3) @(posedge sys_clk);          // aligned crosses in 2 sys edges
                post_sys_check(2'd1, t_fld[i][4]);
            end
            default: post_sys_check(2'd2, t_fld[i][4]);  // slide pulse count
        endcase
    endtask

    task automatic close_test(input int tn);
        @(posedge evrClk);
        exp_rx_valid <= 1'b0;
        rx_data.word <= '0;                             // clean word without comma or error
        rx_is_k      <= '0;
        rx_nit       <= '0;
        rx_disp      <= '0;
        repeat (2) @(posedge evrClk);                   // let the last compare happen
        test_num <= tn;
        test_end <= 1'b1;
        @(posedge evrClk);
        test_end <= 1'b0;
        @(posedge evrClk);                              // test tally settled in the checker
    endtask

    task automatic finish_run(input bit aborted);
        $display("tests passed %0d, tests failed %0d, other errors %0d", passed, failed, tb_errs);
        if (!aborted && failed == 0 && tb_errs == 0 && passed > 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    initial begin : main
        int n_lines;
        void'($urandom(98));
        rst_n = 1'b0;
        rx_data = '0;
        rx_is_k = '0;
        rx_nit = '0;
        rx_disp = '0;
        gpio = '0;
        csr_strobe = 1'b0;
        exp_rx_valid = 1'b0;
        exp_chars = '0;
        exp_k = '0;
        exp_sync = 1'b0;
        exp_sys_valid = 1'b0;
        exp_sys_kind = '0;
        exp_sys_val = '0;
        test_num = 0;
        test_end = 1'b0;
        load_trace(n_lines);
        for (int i = 0; i < n_lines; i++) begin
            steps_total += (t_op[i] <= 1) ? t_rep[i] : 1;
        end
        if (n_lines == 0) begin
            $display("evr_rx_trace.txt missing or holds no usable lines");
            finish_run(1'b1);
        end else begin
            repeat (10) @(posedge evrClk);
            rst_n <= 1'b1;
            for (int i = 0; i < n_lines; i++) begin
                run_step(i);
                if (i == n_lines - 1 || t_test[i + 1] != t_test[i]) close_test(t_test[i]);
            end
            finish_run(1'b0);
        end
    end

    // run limit scales with the trace length plus reset
    initial begin : watchdog
        wait (steps_total > 0);
        #((steps_total + 10) * SYS_PERIOD * 4);
        $display("timeout, trace did not finish in time");
        finish_run(1'b1);
    end

endmodule

//--- evr_rx_trace.txt
# test op rep data is_k nit disp exp0 exp1 exp2
# op 0 rx word (exp0 chars, exp1 is_k, exp2 synced), 1 random idle (exp0 1 = passes through)
# op 2 csr write (data = gpio, exp0 = mgt reset), 3 status (exp0), 4 slide pulse count (exp0)
1 1 2 0000     0 0 0 0        0 0
1 0 7 50bc     1 0 0 0000     0 0
1 1 1 0000     0 0 0 0        0 0
2 0 1 50bc     1 0 0 0000     0 1
2 0 1 1234     0 0 0 1234     0 1
2 1 2 0000     0 0 0 1        0 1
2 0 1 50bc     1 0 0 50bc     1 1
3 0 1 5555     0 0 1 0000     0 0
3 0 3 50bc     1 0 0 0000     0 0
3 0 1 aaaa     0 2 0 0000     0 0
3 0 7 50bc     1 0 0 0000     0 0
3 0 1 50bc     1 0 0 0000     0 1
3 0 1 bc00     2 0 0 0000     0 0
3 0 7 50bc     1 0 0 0000     0 0
3 0 1 50bc     1 0 0 0000     0 1
3 1 2 0000     0 0 0 1        0 1
4 2 1 22000000 0 0 0 11       0 0
4 3 1 00000000 0 0 0 a2000000 0 0
5 2 1 40000000 0 0 0 00       0 0
5 2 1 00000000 0 0 0 00       0 0
5 2 1 40000000 0 0 0 00       0 0
5 2 1 00000000 0 0 0 00       0 0
5 4 1 00000000 0 0 0 2        0 0
5 3 1 00000000 0 0 0 80000000 0 0

//--- vlog.f
evr_rx_pkg.sv
evr_comma_align.sv
evr_slide_sync.sv
evr_mgt_csr.sv
evr_rx_framer.sv
evr_rx_checker.sv
tb_evr_rx_framer.sv

//--- run_sim.sh
#!/bin/sh
# build and run the framer testbench, result taken from the log
verilator --binary --assert --top-module tb_evr_rx_framer -f vlog.f -o sim_evr_rx || exit 1
./obj_dir/sim_evr_rx 2>&1 | tee sim.log
grep -q "sim failed" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "sim passed" sim.log && echo "simulation ok" || { echo "no result in log"; exit 1; }
